/* common/dtim_consts.svh */
`ifndef DTIM_CONSTS_SVH
`define DTIM_CONSTS_SVH

// ----------------------------------------------------------------------
// line store geometry
// ----------------------------------------------------------------------

// line index width, 16 lines.
`define DTIM_DEPTH 4

// word offset width, 4 words per line.
`define DTIM_WIDTH 2

// tag width left over from a 32-bit byte address.
`define DTIM_TAG_BITS (30 - `DTIM_DEPTH - `DTIM_WIDTH)

// ----------------------------------------------------------------------
// cached address window, the top bound is exclusive
// ----------------------------------------------------------------------

`define DTIM_BASE_ADDR 32'h0000_1000
`define DTIM_TOP_ADDR 32'h0000_2000

`endif

/* common/dtim_pkg.sv */
`default_nettype none

`include "dtim_consts.svh"

package dtim_pkg;

  typedef logic [31:0] dtim_word_t;
  typedef logic [3:0] dtim_strb_t;

  typedef logic [`DTIM_TAG_BITS-1:0] dtim_tag_t;
  typedef logic [`DTIM_DEPTH-1:0] dtim_index_t;
  typedef logic [`DTIM_WIDTH-1:0] dtim_offset_t;

  // one line is a packed array of words, so line[offset] selects a word.
  typedef dtim_word_t [2**`DTIM_WIDTH-1:0] dtim_line_t;

  typedef struct packed {
    dtim_tag_t tag;
    dtim_index_t index;
    dtim_offset_t offset;
    logic [1:0] byte_off;
  } dtim_addr_fields_t;

  // the request address, seen either flat or split into its line fields.
  typedef union packed {
    dtim_word_t flat;
    dtim_addr_fields_t field;
  } dtim_addr_t;

  typedef enum logic [2:0] {
    st_lookup,
    st_refill,
    st_uncached,
    st_update,
    st_fence_scan,
    st_writeback
  } dtim_state_t;

endpackage

`default_nettype wire

/* common/dtim_array_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface dtim_array_if
  import dtim_pkg::*;
();

  // write side.
  logic wen;
  dtim_index_t waddr;
  dtim_tag_t wtag;
  logic wlock;
  dtim_line_t wline;

  // read side, data follows raddr by one cycle.
  dtim_index_t raddr;
  dtim_tag_t rtag;
  logic rlock;
  dtim_line_t rline;

  modport ctrl (
    output wen, waddr, raddr, wtag, wlock, wline,
    input rtag, rlock, rline
  );

  modport array (
    input wen, waddr, raddr, wtag, wlock, wline,
    output rtag, rlock, rline
  );

endinterface

`default_nettype wire

/* dtim/dtim_tag_array.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dtim_consts.svh"

module dtim_tag_array
  import dtim_pkg::*;
(
  input logic clock,
  input logic reset,
  dtim_array_if.array port
);

  localparam int lines = 2 ** `DTIM_DEPTH;

  dtim_tag_t tag_mem [lines];
  logic [lines-1:0] lock_bits;
  dtim_index_t raddr_q;

  // the lock bits mark which lines are present, so they start cleared.
  always_ff @(posedge clock) begin
    if (!reset) begin
      raddr_q <= '0;
      lock_bits <= '0;
    end else begin
      raddr_q <= port.raddr;
      if (port.wen) begin
        lock_bits[port.waddr] <= port.wlock;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (port.wen) begin
      tag_mem[port.waddr] <= port.wtag;
    end
  end

  assign port.rtag = tag_mem[raddr_q];
  assign port.rlock = lock_bits[raddr_q];

  // this store keeps no line data.
  assign port.rline = '0;

endmodule

`default_nettype wire

/* dtim/dtim_data_array.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dtim_consts.svh"

module dtim_data_array
  import dtim_pkg::*;
(
  input logic clock,
  dtim_array_if.array port
);

  localparam int lines = 2 ** `DTIM_DEPTH;

  dtim_line_t line_mem [lines];
  dtim_index_t raddr_q;

  // lines are always written whole.
  always_ff @(posedge clock) begin
    raddr_q <= port.raddr;
    if (port.wen) begin
      line_mem[port.waddr] <= port.wline;
    end
  end

  assign port.rline = line_mem[raddr_q];

  // tag and lock live in the tag store.
  assign port.rtag = '0;
  assign port.rlock = 1'b0;

endmodule

`default_nettype wire

/* dtim/dtim_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dtim_consts.svh"

module dtim_ctrl
  import dtim_pkg::*;
(
  input logic clock,
  input logic reset,
  dtim_array_if.ctrl tag_port,
  dtim_array_if.ctrl data_port,
  input logic dtim_valid,
  input logic dtim_fence,
  input dtim_word_t dtim_addr,
  input dtim_word_t dtim_wdata,
  input dtim_strb_t dtim_wstrb,
  output dtim_word_t dtim_rdata,
  output logic dtim_ready,
  output logic dmem_valid,
  output dtim_word_t dmem_addr,
  output dtim_word_t dmem_wdata,
  output dtim_strb_t dmem_wstrb,
  input dtim_word_t dmem_rdata,
  input logic dmem_ready
);

  dtim_addr_t req_addr;

  logic f_rden;
  logic f_wren;
  logic f_fence;
  dtim_addr_t f_addr;
  dtim_word_t f_wdata;
  dtim_strb_t f_wstrb;
  dtim_index_t f_index;
  dtim_index_t f_index_next;

  dtim_state_t state;
  dtim_state_t state_next;
  dtim_addr_t b_addr;
  dtim_addr_t addr_next;
  dtim_line_t b_line;
  dtim_line_t line_next;
  dtim_offset_t cnt;
  dtim_offset_t cnt_next;
  logic mem_valid;
  logic mem_valid_next;
  dtim_offset_t b_offset;
  dtim_word_t b_wdata;
  dtim_strb_t b_wstrb;
  logic b_store;

  logic in_window;
  logic scan_step;
  logic array_wen;
  logic lock_wen;
  dtim_line_t merge_line;

  // ----------------------------------------------------------------------
  // front stage
  // ----------------------------------------------------------------------

  assign req_addr = dtim_addr;

  // the front index is also the array read index. A fence starts at line 0.
  always_comb begin
    if (dtim_valid) begin
      f_index_next = dtim_fence ? '0 : req_addr.field.index;
    end else if (scan_step) begin
      f_index_next = f_index + 1'b1;
    end else begin
      f_index_next = f_index;
    end
  end

  assign tag_port.raddr = f_index_next;
  assign data_port.raddr = f_index_next;

  assign in_window = (f_addr.flat >= `DTIM_BASE_ADDR) && (f_addr.flat < `DTIM_TOP_ADDR);

  // ----------------------------------------------------------------------
  // back stage
  // ----------------------------------------------------------------------

  always_comb begin
    state_next = state;
    addr_next = b_addr;
    line_next = b_line;
    cnt_next = cnt;
    mem_valid_next = mem_valid;
    scan_step = 1'b0;
    array_wen = 1'b0;
    lock_wen = 1'b0;
    dtim_ready = 1'b0;
    dtim_rdata = '0;
    case (state)
      st_lookup: begin
        if (f_fence) begin
          state_next = st_fence_scan;
        end else if (f_rden || f_wren) begin
          addr_next = f_addr;
          if (!in_window) begin
            state_next = st_uncached;
            mem_valid_next = 1'b1;
          end else if (!tag_port.rlock) begin
            // fill the whole line from its first word.
            addr_next.field.offset = '0;
            addr_next.field.byte_off = '0;
            cnt_next = '0;
            state_next = st_refill;
            mem_valid_next = 1'b1;
          end else if (tag_port.rtag != f_addr.field.tag) begin
            state_next = st_uncached;
            mem_valid_next = 1'b1;
          end else if (f_wren) begin
            line_next = data_port.rline;
            state_next = st_update;
          end else begin
            dtim_ready = 1'b1;
            dtim_rdata = data_port.rline[f_addr.field.offset];
          end
        end
      end
      st_refill: begin
        if (dmem_ready) begin
          line_next[cnt] = dmem_rdata;
          if (cnt == '1) begin
            mem_valid_next = 1'b0;
            state_next = st_update;
          end else begin
            cnt_next = cnt + 1'b1;
            addr_next.field.offset = cnt_next;
          end
        end
      end
      st_uncached: begin
        dtim_ready = dmem_ready;
        dtim_rdata = dmem_rdata;
        if (dmem_ready) begin
          mem_valid_next = 1'b0;
          state_next = st_lookup;
        end
      end
      st_update: begin
        array_wen = 1'b1;
        dtim_ready = 1'b1;
        dtim_rdata = merge_line[b_offset];
        state_next = st_lookup;
      end
      st_fence_scan: begin
        if (tag_port.rlock) begin
          line_next = data_port.rline;
          addr_next.flat = '0;
          addr_next.field.tag = tag_port.rtag;
          addr_next.field.index = f_index;
          cnt_next = '0;
          mem_valid_next = 1'b1;
          state_next = st_writeback;
        end else if (f_index == '1) begin
          dtim_ready = 1'b1;
          state_next = st_lookup;
        end else begin
          scan_step = 1'b1;
        end
      end
      st_writeback: begin
        if (dmem_ready) begin
          if (cnt == '1) begin
            // the last word is out, so the lock is cleared.
            mem_valid_next = 1'b0;
            lock_wen = 1'b1;
            if (f_index == '1) begin
              dtim_ready = 1'b1;
              state_next = st_lookup;
            end else begin
              scan_step = 1'b1;
              state_next = st_fence_scan;
            end
          end else begin
            cnt_next = cnt + 1'b1;
            addr_next.field.offset = cnt_next;
          end
        end
      end
      default: begin
        state_next = st_lookup;
      end
    endcase
  end

  // store bytes go into the buffered line under their strobes.
  always_comb begin
    merge_line = b_line;
    if (b_store) begin
      for (int i = 0; i < 4; i++) begin
        if (b_wstrb[i]) begin
          merge_line[b_offset][8*i +: 8] = b_wdata[8*i +: 8];
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // array and memory outputs
  // ----------------------------------------------------------------------

  // update sets the lock, the end of a writeback clears it.
  assign tag_port.wen = array_wen | lock_wen;
  assign tag_port.waddr = b_addr.field.index;
  assign tag_port.wtag = b_addr.field.tag;
  assign tag_port.wlock = array_wen;
  assign tag_port.wline = merge_line;

  assign data_port.wen = array_wen;
  assign data_port.waddr = b_addr.field.index;
  assign data_port.wtag = b_addr.field.tag;
  assign data_port.wlock = array_wen;
  assign data_port.wline = merge_line;

  assign dmem_valid = mem_valid;
  assign dmem_addr = b_addr.flat;
  assign dmem_wdata = (state == st_writeback) ? b_line[cnt] : b_wdata;
  assign dmem_wstrb = (state == st_writeback) ? 4'hF :
                      (state == st_uncached) ? b_wstrb : '0;

  // ----------------------------------------------------------------------
  // registers
  // ----------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (!reset) begin
      f_rden <= 1'b0;
      f_wren <= 1'b0;
      f_fence <= 1'b0;
      f_index <= '0;
      state <= st_lookup;
      cnt <= '0;
      mem_valid <= 1'b0;
    end else begin
      f_rden <= dtim_valid && !dtim_fence && !(|dtim_wstrb);
      f_wren <= dtim_valid && !dtim_fence && (|dtim_wstrb);
      f_fence <= dtim_valid && dtim_fence;
      f_index <= f_index_next;
      state <= state_next;
      cnt <= cnt_next;
      mem_valid <= mem_valid_next;
    end
  end

  always_ff @(posedge clock) begin
    if (dtim_valid) begin
      f_addr <= req_addr;
      f_wdata <= dtim_wdata;
      f_wstrb <= dtim_wstrb;
    end
    if (state == st_lookup) begin
      b_offset <= f_addr.field.offset;
      b_wdata <= f_wdata;
      b_wstrb <= f_wstrb;
      b_store <= f_wren;
    end
    b_addr <= addr_next;
    b_line <= line_next;
  end

endmodule

`default_nettype wire

/* design/dtim_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dtim_top
  import dtim_pkg::*;
(
  input logic clock,
  input logic reset,

  // processor load/store port.
  input logic dtim_valid,
  input logic dtim_fence,
  input dtim_word_t dtim_addr,
  input dtim_word_t dtim_wdata,
  input dtim_strb_t dtim_wstrb,
  output dtim_word_t dtim_rdata,
  output logic dtim_ready,

  // data memory port.
  output logic dmem_valid,
  output dtim_word_t dmem_addr,
  output dtim_word_t dmem_wdata,
  output dtim_strb_t dmem_wstrb,
  input dtim_word_t dmem_rdata,
  input logic dmem_ready
);

  dtim_array_if tag_port ();
  dtim_array_if data_port ();

  dtim_tag_array dtim_tag_array_i (
    .clock (clock),
    .reset (reset),
    .port  (tag_port.array)
  );

  dtim_data_array dtim_data_array_i (
    .clock (clock),
    .port  (data_port.array)
  );

  dtim_ctrl dtim_ctrl_i (
    .clock      (clock),
    .reset      (reset),
    .tag_port   (tag_port.ctrl),
    .data_port  (data_port.ctrl),
    .dtim_valid (dtim_valid),
    .dtim_fence (dtim_fence),
    .dtim_addr  (dtim_addr),
    .dtim_wdata (dtim_wdata),
    .dtim_wstrb (dtim_wstrb),
    .dtim_rdata (dtim_rdata),
    .dtim_ready (dtim_ready),
    .dmem_valid (dmem_valid),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .dmem_rdata (dmem_rdata),
    .dmem_ready (dmem_ready)
  );

endmodule

`default_nettype wire

/* test/dtim_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module dtim_clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // reset is held low through the first four rising edges.
  initial begin
    reset = 1'b0;
    repeat (4) @(posedge clock);
    reset <= 1'b1;
  end

endmodule

`default_nettype wire

/* test/dtim_props.sv */
`timescale 1ns/100ps
`default_nettype none

module dtim_props
  import dtim_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic dtim_valid,
  input logic dtim_fence,
  input dtim_strb_t dtim_wstrb,
  input logic dtim_ready,
  input logic dmem_valid,
  input dtim_word_t dmem_addr,
  input dtim_word_t dmem_wdata,
  input dtim_strb_t dmem_wstrb,
  input logic dmem_ready
);

  logic pending;

  // a request is outstanding from its valid pulse until its ready pulse.
  always_ff @(posedge clock) begin
    if (!reset) begin
      pending <= 1'b0;
    end else if (dtim_valid) begin
      pending <= 1'b1;
    end else if (dtim_ready) begin
      pending <= 1'b0;
    end
  end

  assert property (@(posedge clock) disable iff (!reset)
    dmem_valid && !dmem_ready |=> dmem_valid && $stable(dmem_addr) &&
      $stable(dmem_wdata) && $stable(dmem_wstrb))
    else $error("dmem request changed while waiting for dmem_ready");

  assert property (@(posedge clock) disable iff (!reset)
    dtim_ready |-> pending)
    else $error("dtim_ready pulsed with no outstanding request");

  // a load answered one cycle after its request can only be a hit,
  // and a hit starts no memory access afterwards either.
  assert property (@(posedge clock) disable iff (!reset)
    $past(dtim_valid && !dtim_fence && dtim_wstrb == 4'h0) && dtim_ready |->
      !dmem_valid ##1 !dmem_valid)
    else $error("dmem_valid raised during a read hit");

endmodule

bind dtim_top dtim_props dtim_props_i (
  .clock      (clock),
  .reset      (reset),
  .dtim_valid (dtim_valid),
  .dtim_fence (dtim_fence),
  .dtim_wstrb (dtim_wstrb),
  .dtim_ready (dtim_ready),
  .dmem_valid (dmem_valid),
  .dmem_addr  (dmem_addr),
  .dmem_wdata (dmem_wdata),
  .dmem_wstrb (dmem_wstrb),
  .dmem_ready (dmem_ready)
);

`default_nettype wire

/* test/dtim_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dtim_consts.svh"

module dtim_tb
  import dtim_pkg::*;
();

  localparam int mem_words = 4096;
  localparam int lines = 2 ** `DTIM_DEPTH;
  localparam int timeout = 2000;
  localparam int op_load = 0;
  localparam int op_store = 1;
  localparam int op_fence = 2;
  localparam int op_memchk = 3;

  logic clock;
  logic reset;
  logic dtim_valid;
  logic dtim_fence;
  dtim_word_t dtim_addr;
  dtim_word_t dtim_wdata;
  dtim_strb_t dtim_wstrb;
  dtim_word_t dtim_rdata;
  logic dtim_ready;
  logic dmem_valid;
  dtim_word_t dmem_addr;
  dtim_word_t dmem_wdata;
  dtim_strb_t dmem_wstrb;
  dtim_word_t dmem_rdata;
  logic dmem_ready;

  dtim_word_t mem [mem_words];
  dtim_word_t shadow_mem [mem_words];
  logic [31:0] rng;
  int wait_cnt;
  int delay;

  // expected line store contents.
  logic ref_lock [lines];
  dtim_tag_t ref_tag [lines];
  dtim_line_t ref_line [lines];

  string row_name [$];
  int row_op [$];
  dtim_word_t row_addr [$];
  dtim_word_t row_wdata [$];
  dtim_strb_t row_strb [$];
  dtim_word_t row_expect [$];
  logic row_mem_use [$];

  dtim_clock_gen dtim_clock_gen_i (
    .clock (clock),
    .reset (reset)
  );

  dtim_top dtim_top_i (
    .clock      (clock),
    .reset      (reset),
    .dtim_valid (dtim_valid),
    .dtim_fence (dtim_fence),
    .dtim_addr  (dtim_addr),
    .dtim_wdata (dtim_wdata),
    .dtim_wstrb (dtim_wstrb),
    .dtim_rdata (dtim_rdata),
    .dtim_ready (dtim_ready),
    .dmem_valid (dmem_valid),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .dmem_rdata (dmem_rdata),
    .dmem_ready (dmem_ready)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic dtim_word_t merge_bytes(input dtim_word_t old, input dtim_word_t data,
                                             input dtim_strb_t strb);
    dtim_word_t res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = data[8*i +: 8];
      end
    end
    return res;
  endfunction

  // ----------------------------------------------------------------------
  // memory model
  // ----------------------------------------------------------------------

  // each held request gets one ready pulse after 1 to 3 cycles.
  always @(posedge clock) begin
    if (!reset) begin
      dmem_ready <= 1'b0;
      wait_cnt <= 0;
      delay <= 1;
    end else begin
      dmem_ready <= 1'b0;
      if (dmem_valid && !dmem_ready) begin
        if (wait_cnt + 1 >= delay) begin
          dmem_ready <= 1'b1;
          dmem_rdata <= mem[dmem_addr[13:2]];
          mem[dmem_addr[13:2]] = merge_bytes(mem[dmem_addr[13:2]], dmem_wdata, dmem_wstrb);
          rng = xorshift32(rng);
          delay <= 1 + int'(rng % 3);
          wait_cnt <= 0;
        end else begin
          wait_cnt <= wait_cnt + 1;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // table, expected values and checks
  // ----------------------------------------------------------------------

  task automatic stop_run(input string what);
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_rdata(input string name, input dtim_word_t expected,
                             input dtim_word_t actual);
    if (actual !== expected) begin
      stop_run($sformatf("mismatch %s rdata expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_mem_word(input string name, input dtim_word_t expected,
                                input dtim_word_t actual);
    if (actual !== expected) begin
      stop_run($sformatf("mismatch %s memory expected %h actual %h", name, expected, actual));
    end
  endtask

  // runs the request through the expected line store and memory, then queues the row.
  task automatic add_row(input string name, input int op, input dtim_word_t addr,
                         input dtim_word_t wdata, input dtim_strb_t strb);
    dtim_addr_t a;
    dtim_addr_t b;
    dtim_index_t idx;
    dtim_word_t expect_word;
    logic mem_use;
    a.flat = addr;
    idx = a.field.index;
    expect_word = '0;
    mem_use = 1'b1;
    if (op == op_fence) begin
      mem_use = 1'b0;
      for (int i = 0; i < lines; i++) begin
        if (ref_lock[i]) begin
          mem_use = 1'b1;
          for (int j = 0; j < 4; j++) begin
            b.flat = '0;
            b.field.tag = ref_tag[i];
            b.field.index = dtim_index_t'(i);
            b.field.offset = dtim_offset_t'(j);
            shadow_mem[b.flat[13:2]] = ref_line[i][j];
          end
          ref_lock[i] = 1'b0;
        end
      end
    end else if (op == op_memchk) begin
      mem_use = 1'b0;
      expect_word = shadow_mem[addr[13:2]];
    end else if (addr < `DTIM_BASE_ADDR || addr >= `DTIM_TOP_ADDR ||
                 (ref_lock[idx] && ref_tag[idx] != a.field.tag)) begin
      expect_word = shadow_mem[addr[13:2]];
      shadow_mem[addr[13:2]] = merge_bytes(shadow_mem[addr[13:2]], wdata, strb);
    end else begin
      if (ref_lock[idx]) begin
        mem_use = 1'b0;
      end else begin
        for (int j = 0; j < 4; j++) begin
          b = a;
          b.field.offset = dtim_offset_t'(j);
          ref_line[idx][j] = shadow_mem[b.flat[13:2]];
        end
        ref_lock[idx] = 1'b1;
        ref_tag[idx] = a.field.tag;
      end
      ref_line[idx][a.field.offset] = merge_bytes(ref_line[idx][a.field.offset], wdata, strb);
      expect_word = ref_line[idx][a.field.offset];
    end
    row_name.push_back(name);
    row_op.push_back(op);
    row_addr.push_back(addr);
    row_wdata.push_back(wdata);
    row_strb.push_back(strb);
    row_expect.push_back(expect_word);
    row_mem_use.push_back(mem_use);
  endtask

  task automatic apply_row(input int n);
    int cycles;
    logic mem_seen;
    if (row_op[n] == op_memchk) begin
      check_mem_word(row_name[n], row_expect[n], mem[row_addr[n][13:2]]);
    end else begin
      @(posedge clock);
      dtim_valid <= 1'b1;
      dtim_fence <= (row_op[n] == op_fence);
      dtim_addr <= row_addr[n];
      dtim_wdata <= row_wdata[n];
      dtim_wstrb <= row_strb[n];
      @(posedge clock);
      dtim_valid <= 1'b0;
      dtim_fence <= 1'b0;
      cycles = 0;
      mem_seen = 1'b0;
      do begin
        @(negedge clock);
        mem_seen = mem_seen | dmem_valid;
        cycles++;
        if (cycles > timeout) begin
          stop_run($sformatf("timeout waiting for dtim_ready in %s", row_name[n]));
        end
      end while (dtim_ready !== 1'b1);
      check_rdata(row_name[n], row_expect[n], dtim_rdata);
      if (mem_seen !== row_mem_use[n]) begin
        stop_run($sformatf("mismatch %s dmem use expected %0d actual %0d", row_name[n],
                           row_mem_use[n], mem_seen));
      end
    end
  endtask

  initial begin
    int cycles;
    dtim_valid = 1'b0;
    dtim_fence = 1'b0;
    dtim_addr = '0;
    dtim_wdata = '0;
    dtim_wstrb = '0;
    dmem_rdata = '0;
    dmem_ready = 1'b0;
    rng = 32'd60681;
    for (int i = 0; i < mem_words; i++) begin
      rng = xorshift32(rng);
      mem[i] = rng;
      shadow_mem[i] = rng;
    end
    for (int i = 0; i < lines; i++) begin
      ref_lock[i] = 1'b0;
      ref_tag[i] = '0;
      ref_line[i] = '0;
    end

    add_row("refill_read", op_load, 32'h0000_1014, '0, 4'h0);
    add_row("hit_same_word", op_load, 32'h0000_1014, '0, 4'h0);
    add_row("hit_other_word", op_load, 32'h0000_101c, '0, 4'h0);
    add_row("store_hit_partial", op_store, 32'h0000_1018, 32'ha5a5_5a5a, 4'b0101);
    add_row("read_merged", op_load, 32'h0000_1018, '0, 4'h0);
    add_row("mem_kept_on_hit", op_memchk, 32'h0000_1018, '0, 4'h0);
    add_row("store_refill", op_store, 32'h0000_1024, 32'hdead_beef, 4'b1100);
    add_row("read_store_refill", op_load, 32'h0000_1024, '0, 4'h0);
    add_row("read_below_window", op_load, 32'h0000_0240, '0, 4'h0);
    add_row("store_below_window", op_store, 32'h0000_0240, 32'h1234_5678, 4'hf);
    add_row("mem_below_window", op_memchk, 32'h0000_0240, '0, 4'h0);
    add_row("read_back_below", op_load, 32'h0000_0240, '0, 4'h0);
    add_row("store_at_top", op_store, 32'h0000_2000, 32'h0bad_f00d, 4'b0011);
    add_row("mem_at_top", op_memchk, 32'h0000_2000, '0, 4'h0);
    add_row("read_tag_conflict", op_load, 32'h0000_1114, '0, 4'h0);
    add_row("store_tag_conflict", op_store, 32'h0000_1118, 32'hc3c3_3c3c, 4'b1000);
    add_row("mem_tag_conflict", op_memchk, 32'h0000_1118, '0, 4'h0);
    add_row("locked_line_kept", op_load, 32'h0000_1018, '0, 4'h0);
    add_row("fence", op_fence, '0, '0, 4'h0);
    add_row("mem_merged_word", op_memchk, 32'h0000_1018, '0, 4'h0);
    add_row("mem_refill_store", op_memchk, 32'h0000_1024, '0, 4'h0);
    add_row("mem_line_rest", op_memchk, 32'h0000_1010, '0, 4'h0);
    add_row("refill_after_fence", op_load, 32'h0000_1018, '0, 4'h0);
    add_row("hit_after_fence", op_load, 32'h0000_101c, '0, 4'h0);

    cycles = 0;
    while (reset !== 1'b1) begin
      @(negedge clock);
      cycles++;
      if (cycles > 20) begin
        stop_run("reset was never released");
      end
    end

    for (int n = 0; n < row_name.size(); n++) begin
      apply_row(n);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+common
common/dtim_pkg.sv
common/dtim_array_if.sv
dtim/dtim_tag_array.sv
dtim/dtim_data_array.sv
dtim/dtim_ctrl.sv
design/dtim_top.sv
test/dtim_clock_gen.sv
test/dtim_props.sv
test/dtim_tb.sv
